/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

   // ====================
   // frame constants
   // ====================

   localparam int data_bits  = 8;
   localparam int frame_bits = 11;   // start, eight data bits, parity and stop.
   localparam int cmd_bits   = 16;

   // ====================
   // shared types
   // ====================

   // Bit 0 is the start bit, so shifting right sends the frame in line order.
   typedef struct packed {
      logic                 stop;
      logic                 parity;
      logic [data_bits-1:0] data;
      logic                 start;
   } uart_frame_t;

   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 parity_err;
      logic                 frame_err;    // set when the stop sample was low.
   } rx_byte_t;

   // ====================
   // helpers
   // ====================

   function automatic logic odd_parity(input logic [data_bits-1:0] data);
      return ~^data;   // one when data holds an even number of ones.
   endfunction

   function automatic uart_frame_t make_frame(input logic [data_bits-1:0] data);
      uart_frame_t frame;
      frame.start  = 1'b0;
      frame.data   = data;
      frame.parity = odd_parity(data);
      frame.stop   = 1'b1;
      return frame;
   endfunction

endpackage

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
   parameter int clks_per_bit = 4
) (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire [uart_pkg::cmd_bits-1:0] cmd_in,
   input  wire                          cmd_vld,
   output logic                         cmd_rdy,
   output logic                         tx
);

   localparam int cnt_w      = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int total_bits = 2 * uart_pkg::frame_bits;
   localparam int bit_w      = $clog2(total_bits);

   localparam logic [cnt_w-1:0] last_clk = cnt_w'(clks_per_bit - 1);
   localparam logic [bit_w-1:0] last_bit = bit_w'(total_bits - 1);

   logic [cnt_w-1:0]      clk_cnt;
   logic [bit_w-1:0]      bit_cnt;
   logic [total_bits-1:0] shift_q;
   uart_pkg::uart_frame_t hi_frame;
   uart_pkg::uart_frame_t lo_frame;
   logic                  accept;
   logic                  bit_end;

   // ====================
   // frame build
   // ====================

   assign hi_frame = uart_pkg::make_frame(cmd_in[uart_pkg::cmd_bits-1 -: uart_pkg::data_bits]);
   assign lo_frame = uart_pkg::make_frame(cmd_in[uart_pkg::data_bits-1:0]);

   assign accept  = cmd_vld && cmd_rdy;
   assign bit_end = (clk_cnt == last_clk);

   assign tx = shift_q[0];   // the register fills with ones, so the line idles high.

   // ====================
   // bit timing
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         cmd_rdy <= 1'b1;
      end
      else if (accept)
      begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         cmd_rdy <= 1'b0;
      end
      else if (!cmd_rdy)
      begin
         if (bit_end)
         begin
            clk_cnt <= '0;
            if (bit_cnt == last_bit)
            begin
               bit_cnt <= '0;
               cmd_rdy <= 1'b1;   // ready again right after the second stop bit.
            end
            else
            begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
         else
         begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // ====================
   // shift register
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         shift_q <= '1;
      end
      else if (accept)
      begin
         shift_q <= {lo_frame, hi_frame};   // high byte sits in the low bits and goes first.
      end
      else if (!cmd_rdy && bit_end)
      begin
         shift_q <= {1'b1, shift_q[total_bits-1:1]};
      end
   end

   // ====================
   // assertions
   // ====================

   a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
      else $error("tx is low while the transmitter is idle");

   a_bit_range: assert property (@(posedge clk) disable iff (!rst_n) bit_cnt <= last_bit)
      else $error("bit counter passed the last bit of the command");

endmodule

`default_nettype wire

/* hw/uart_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
   parameter int clks_per_bit = 4
) (
   input  wire                clk,
   input  wire                rst_n,
   input  wire                rx,
   output logic               read_rdy,
   output uart_pkg::rx_byte_t read_byte
);

   localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam int idx_w = $clog2(uart_pkg::data_bits);

   localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2);
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(clks_per_bit - 1);
   localparam logic [idx_w-1:0] last_idx = idx_w'(uart_pkg::data_bits - 1);

   typedef enum logic [2:0] {
      st_idle,
      st_start,
      st_data,
      st_parity,
      st_stop
   } rx_state_t;

   rx_state_t                     state;
   logic                          rx_meta;
   logic                          rx_sync;
   logic                          rx_last;
   logic [cnt_w-1:0]              cnt;
   logic [idx_w-1:0]              bit_idx;
   logic [uart_pkg::data_bits-1:0] data_sr;
   logic                          parity_bit;
   logic                          fall;
   logic                          mid;

   // ====================
   // line synchronizer
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_last <= 1'b1;
      end
      else
      begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_last <= rx_sync;   // samples are taken from this copy, one cycle behind the edge.
      end
   end

   assign fall = rx_last && !rx_sync;

   // the start bit waits half a period and every later bit a full one.
   assign mid = (state == st_start) ? (cnt == half_cnt) : (cnt == full_cnt);

   // ====================
   // state machine
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state   <= st_idle;
         cnt     <= '0;
         bit_idx <= '0;
      end
      else
      begin
         if (state == st_idle || mid)
            cnt <= '0;
         else
            cnt <= cnt + 1'b1;

         unique case (state)
            st_idle:
            begin
               if (fall)
                  state <= st_start;
            end
            st_start:
            begin
               if (mid)
               begin
                  bit_idx <= '0;
                  state   <= rx_last ? st_idle : st_data;   // a high mid-sample was a glitch.
               end
            end
            st_data:
            begin
               if (mid)
               begin
                  if (bit_idx == last_idx)
                     state <= st_parity;
                  else
                     bit_idx <= bit_idx + 1'b1;
               end
            end
            st_parity:
            begin
               if (mid)
                  state <= st_stop;
            end
            st_stop:
            begin
               if (mid)
                  state <= st_idle;
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (mid && state == st_data)
         data_sr <= {rx_last, data_sr[uart_pkg::data_bits-1:1]};   // lsb arrives first.
      if (mid && state == st_parity)
         parity_bit <= rx_last;
   end

   // ====================
   // byte output
   // ====================

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         read_rdy  <= 1'b0;
         read_byte <= '0;
      end
      else if (mid && state == st_stop)
      begin
         read_rdy             <= 1'b1;
         read_byte.data       <= data_sr;
         read_byte.parity_err <= (parity_bit != uart_pkg::odd_parity(data_sr));
         read_byte.frame_err  <= !rx_last;
      end
      else
      begin
         read_rdy <= 1'b0;
      end
   end

   a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
      else $error("read_rdy held high for two cycles");

   a_legal_state: assert property (@(posedge clk) disable iff (!rst_n)
      state inside {st_idle, st_start, st_data, st_parity, st_stop})
      else $error("receiver state register holds an illegal encoding");

endmodule

`default_nettype wire

/* hw/uart_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_top #(
   parameter int clks_per_bit = 4
) (
   input  wire                          clk,
   input  wire                          rst_n,

   // ====================
   // command side
   // ====================
   input  wire [uart_pkg::cmd_bits-1:0] cmd_in,
   input  wire                          cmd_vld,
   output logic                         cmd_rdy,

   // ====================
   // line side
   // ====================
   output logic                         tx,
   input  wire                          rx,

   // ====================
   // receive side
   // ====================
   output logic                         read_rdy,
   output uart_pkg::rx_byte_t           read_byte
);

   // The two halves run on their own and share nothing but the clock and reset.

   uart_tx #(
      .clks_per_bit (clks_per_bit)
   ) u_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   uart_rx #(
      .clks_per_bit (clks_per_bit)
   ) u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .read_rdy  (read_rdy),
      .read_byte (read_byte)
   );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int period_ns    = 10,
   parameter int reset_cycles = 5
) (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;   // released on a clock edge like any other input.
   end

endmodule

`default_nettype wire

/* dv/uart_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tb;

   localparam int bit_clks     = 4;
   localparam int period_ns    = 10;
   localparam int reset_cycles = 5;
   localparam int num_entries  = 10;
   localparam int wd_ns        = (num_entries * 30 * bit_clks + reset_cycles) * period_ns;
   localparam logic [31:0] seed = 32'h6284_5a81;

   typedef struct packed {
      logic                  inject;
      logic                  glitch;       // one short low pulse ahead of the frame.
      logic                  back_press;
      logic [15:0]           cmd;
      uart_pkg::uart_frame_t frame;
      logic [1:0]            n_exp;
      uart_pkg::rx_byte_t    exp_first;
      uart_pkg::rx_byte_t    exp_second;
   } entry_t;

   wire                clk;
   wire                rst_n;
   wire                rx;
   logic [15:0]        cmd_in;
   logic               cmd_vld;
   logic               cmd_rdy;
   logic               tx;
   logic               read_rdy;
   uart_pkg::rx_byte_t read_byte;
   logic               rx_drv;
   logic               loopback;

   entry_t             stim [num_entries];
   uart_pkg::rx_byte_t got_q [$];
   int                 value_errs = 0;
   int                 pulse_errs = 0;

   tb_clk_gen #(
      .period_ns    (period_ns),
      .reset_cycles (reset_cycles)
   ) u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   assign rx = loopback ? tx : rx_drv;

   uart_top #(
      .clks_per_bit (bit_clks)
   ) i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .rx        (rx),
      .read_rdy  (read_rdy),
      .read_byte (read_byte)
   );

   always @(negedge clk)
   begin
      if (rst_n && read_rdy)
         got_q.push_back(read_byte);
   end

   // ====================
   // reference rules
   // ====================

   function automatic logic ones_parity(input logic [7:0] val);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++)
      begin
         if (val[i])
            ones++;
      end
      return (ones % 2 == 0);   // set when the data alone has an even count.
   endfunction

   // bit idx of a command on the line, high byte frame first, lsb first inside a frame.
   function automatic logic line_bit(input logic [15:0] cmd, input int idx);
      logic [7:0] byte_val;
      int         pos;
      byte_val = (idx < 11) ? cmd[15:8] : cmd[7:0];
      pos      = idx % 11;
      if (pos == 0)
         return 1'b0;
      if (pos <= 8)
         return byte_val[pos-1];
      if (pos == 9)
         return ones_parity(byte_val);
      return 1'b1;
   endfunction

   function automatic entry_t send_entry(input logic [15:0] cmd, input logic bp);
      entry_t e;
      e                 = '0;
      e.cmd             = cmd;
      e.back_press      = bp;
      e.n_exp           = 2'd2;
      e.exp_first.data  = cmd[15:8];
      e.exp_second.data = cmd[7:0];
      return e;
   endfunction

   function automatic entry_t inject_entry(input logic [7:0] data, input logic flip_parity,
                                           input logic stop_low, input logic glitch);
      entry_t e;
      e                      = '0;
      e.inject               = 1'b1;
      e.glitch               = glitch;
      e.frame                = uart_pkg::make_frame(data);
      e.frame.parity         = e.frame.parity ^ flip_parity;
      e.frame.stop           = !stop_low;
      e.n_exp                = 2'd1;
      e.exp_first.data       = data;
      e.exp_first.parity_err = flip_parity;
      e.exp_first.frame_err  = stop_low;
      return e;
   endfunction

   task automatic compare_field(input string sig, input logic [15:0] expected,
                                input logic [15:0] actual);
      if (expected !== actual)
      begin
         value_errs++;
         $display("** Error at %0t ns: %s expected %0h, actual %0h", $time, sig, expected,
                  actual);
      end
   endtask

   // ====================
   // drivers
   // ====================

   task automatic send_command(input logic [15:0] cmd, input logic bp);
      int waited;
      int low_cycles;
      waited     = 0;
      low_cycles = 0;
      @(negedge clk);
      while (!cmd_rdy && waited < 30 * bit_clks)
      begin
         @(negedge clk);
         waited++;
      end
      if (!cmd_rdy)
      begin
         pulse_errs++;
         $display("cmd_rdy stayed low, so command %h could not be offered", cmd);
      end
      else
      begin
         @(posedge clk);
         loopback <= 1'b1;
         cmd_in   <= cmd;
         cmd_vld  <= 1'b1;
         @(posedge clk);   // acceptance edge.
         cmd_vld  <= 1'b0;
         for (int c = 0; c < 22 * bit_clks; c++)
         begin
            @(negedge clk);
            if (!cmd_rdy)
               low_cycles++;
            if (c % bit_clks == bit_clks / 2)
               compare_field($sformatf("tx bit %0d", c / bit_clks),
                             16'(line_bit(cmd, c / bit_clks)), 16'(tx));
            @(posedge clk);
            if (bp && c == 4 * bit_clks)
            begin
               cmd_in  <= ~cmd;   // this one arrives while busy and must be dropped.
               cmd_vld <= 1'b1;
            end
            if (bp && c == 6 * bit_clks)
               cmd_vld <= 1'b0;
         end
         @(negedge clk);
         compare_field("cmd_rdy low cycles", 16'(22 * bit_clks), 16'(low_cycles));
         compare_field("cmd_rdy", 16'h1, 16'(cmd_rdy));
      end
   endtask

   task automatic inject_frame(input uart_pkg::uart_frame_t frame, input logic glitch);
      @(posedge clk);
      loopback <= 1'b0;
      rx_drv   <= 1'b1;
      if (glitch)
      begin
         @(posedge clk);
         rx_drv <= 1'b0;
         @(posedge clk);
         rx_drv <= 1'b1;
         repeat ((uart_pkg::frame_bits + 1) * bit_clks) @(posedge clk);
         if (got_q.size() != 0)
         begin
            pulse_errs++;
            $display("a one-cycle low glitch on rx produced a read_rdy pulse");
            got_q.delete();
         end
      end
      for (int i = 0; i < uart_pkg::frame_bits; i++)
      begin
         @(posedge clk);
         rx_drv <= frame[i];
         repeat (bit_clks - 1) @(posedge clk);
      end
      @(posedge clk);
      rx_drv <= 1'b1;
   endtask

   task automatic collect_bytes(input int idx, input entry_t e);
      int                 waited;
      int                 n;
      uart_pkg::rx_byte_t got;
      uart_pkg::rx_byte_t want;
      waited = 0;
      n      = int'(e.n_exp);
      while (got_q.size() < n && waited < 30 * bit_clks)
      begin
         @(negedge clk);
         waited++;
      end
      repeat (2 * bit_clks) @(negedge clk);   // room for a late extra pulse.
      if (got_q.size() < n)
      begin
         pulse_errs++;
         $display("entry %0d expected %0d read_rdy pulses but saw %0d", idx, n, got_q.size());
      end
      if (got_q.size() > n)
      begin
         pulse_errs++;
         $display("entry %0d gave %0d extra read_rdy pulses", idx, got_q.size() - n);
      end
      for (int i = 0; i < n && i < got_q.size(); i++)
      begin
         got  = got_q[i];
         want = (i == 0) ? e.exp_first : e.exp_second;
         compare_field("read_byte.data", 16'(want.data), 16'(got.data));
         compare_field("read_byte.parity_err", 16'(want.parity_err), 16'(got.parity_err));
         compare_field("read_byte.frame_err", 16'(want.frame_err), 16'(got.frame_err));
      end
      got_q.delete();
   endtask

   // ====================
   // main sequence
   // ====================

   initial
   begin
      int unsigned gap;
      cmd_in   = '0;
      cmd_vld  = 1'b0;
      rx_drv   = 1'b1;
      loopback = 1'b0;
      void'($urandom(seed));
      stim[0] = send_entry(16'h0000, 1'b0);
      stim[1] = send_entry(16'hFFFF, 1'b0);
      stim[2] = send_entry(16'hA55A, 1'b0);
      stim[3] = send_entry(16'h1234, 1'b1);
      stim[4] = inject_entry(8'h3C, 1'b1, 1'b0, 1'b0);
      stim[5] = inject_entry(8'hC7, 1'b0, 1'b1, 1'b0);
      stim[6] = inject_entry(8'h5A, 1'b0, 1'b0, 1'b1);
      stim[7] = inject_entry(8'h07, 1'b1, 1'b0, 1'b0);
      stim[8] = send_entry(16'h8001, 1'b0);
      stim[9] = inject_entry(8'h81, 1'b0, 1'b0, 1'b0);
      wait (rst_n === 1'b1);
      repeat (bit_clks) @(negedge clk);
      compare_field("cmd_rdy", 16'h1, 16'(cmd_rdy));
      compare_field("tx", 16'h1, 16'(tx));
      compare_field("read_byte", 16'h0, 16'(read_byte));
      if (got_q.size() != 0)
      begin
         pulse_errs++;
         $display("read_rdy pulsed after reset with no stimulus applied");
         got_q.delete();
      end
      for (int k = 0; k < num_entries; k++)
      begin
         if (stim[k].inject)
            inject_frame(stim[k].frame, stim[k].glitch);
         else
            send_command(stim[k].cmd, stim[k].back_press);
         collect_bytes(k, stim[k]);
         gap = $urandom % 8;
         repeat (gap) @(posedge clk);
      end
      repeat (4 * bit_clks) @(negedge clk);
      if (got_q.size() != 0)
      begin
         pulse_errs++;
         $display("%0d read_rdy pulses arrived after the last entry", got_q.size());
      end
      $display("value errors: %0d, pulse errors: %0d", value_errs, pulse_errs);
      if (value_errs + pulse_errs == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   initial
   begin
      #(wd_ns);
      $display("watchdog expired before the stimulus table was done");
      $display("value errors: %0d, pulse errors: %0d", value_errs, pulse_errs);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
dv/tb_clk_gen.sv
dv/uart_tb.sv

/* run.sh */
#!/bin/sh
# Build the UART testbench with Verilator, run it, and decide the result from the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module uart_tb \
   -f src.f \
   -o uart_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status, see build.log"
   exit 1
fi

./obj_dir/uart_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" sim.log; then
   echo "RESULT: PASS"
   exit 0
else
   echo "RESULT: FAIL"
   exit 1
fi
